/* mult_mod_pkg.sv */
`default_nettype none
// Shared constants and types for the secp256k1 modular multiplier.
// Every other file refers to these by scoped names.
package mult_mod_pkg;

  // Operand and result width, equal to the field size.
  localparam int FIELD_BITS = 256;
  // Full product width before reduction.
  localparam int PROD_BITS  = 512;
  // Split point of the single Karatsuba level.
  localparam int HALF_BITS  = 128;

  // The secp256k1 prime, 2^256 - 2^32 - 977.
  localparam logic [FIELD_BITS-1:0] PRIME_P =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_FFFFFC2F;

  // Since 2^256 is congruent to 2^32 + 977 mod p, the upper half of a
  // product is folded down by multiplying it with this constant.
  localparam int FOLD_BITS = 33;
  localparam logic [FOLD_BITS-1:0] FOLD_C = 33'h1_0000_03D1;

  // Register stages in the multiplier and in the reduction.
  localparam int MULT_STAGES = 2;
  localparam int MOD_STAGES  = 3;

  // Upper and lower field-sized halves of a product.
  typedef struct packed {
    logic [FIELD_BITS-1:0] hi;
    logic [FIELD_BITS-1:0] lo;
  } prod_halves_t;

  // The multiplier writes the flat word.
  // The reduction reads the same bits as two halves.
  typedef union packed {
    logic [PROD_BITS-1:0] flat;
    prod_halves_t         half;
  } product_t;

endpackage
`default_nettype wire

/* mult_mod_if.sv */
`default_nettype none
// Valid/ready link that carries one 512-bit product with its tag and error flag.
// The producer side uses the src modport and the consumer side uses snk.
interface mult_mod_if #(
  parameter int CTL_BITS = 8
) (
  input wire i_clk
);

  // Payload of one transfer.
  mult_mod_pkg::product_t dat;
  logic [CTL_BITS-1:0]    ctl;
  logic                   err;

  // A transfer happens on a rising edge where both are high.
  logic val;
  logic rdy;

  modport src (
    output dat, ctl, err, val,
    input  rdy
  );

  modport snk (
    input  dat, ctl, err, val,
    output rdy
  );

  // Once offered, an item must stay offered until the consumer takes it.
  // This checks the source and sink of each link together.
  a_val_held: assert property (@(posedge i_clk) val && !rdy |=> val)
    else $error("mult_mod_if: val dropped before the transfer completed");

endinterface
`default_nettype wire

/* karatsuba_mult.sv */
`default_nettype none
// Two-stage pipelined 256 x 256 multiplier using one Karatsuba-Ofman level.
// Inputs use a valid/ready handshake and the 512-bit product leaves on a src link.
// The whole pipe stalls as one unit when the output is full and not taken.
module karatsuba_mult #(
  parameter int CTL_BITS = 8
) (
  input  wire                                i_clk,
  input  wire                                i_rst,
  input  wire [mult_mod_pkg::FIELD_BITS-1:0] i_dat_a,
  input  wire [mult_mod_pkg::FIELD_BITS-1:0] i_dat_b,
  input  wire [CTL_BITS-1:0]                 i_ctl,
  input  wire                                i_err,
  input  wire                                i_val,
  output logic                               o_rdy,
  mult_mod_if.src                            o_prod
);

  // Pipe advance enable, shared by both stages.
  logic en;

  // Sums of the operand halves, one bit wider than a half.
  logic [mult_mod_pkg::HALF_BITS:0] sum_a;
  logic [mult_mod_pkg::HALF_BITS:0] sum_b;

  // Stage one holds the three partial products.
  logic                                 s1_val;
  logic [CTL_BITS-1:0]                  s1_ctl;
  logic                                 s1_err;
  logic [2*mult_mod_pkg::HALF_BITS-1:0] s1_hh;
  logic [2*mult_mod_pkg::HALF_BITS-1:0] s1_ll;
  logic [2*mult_mod_pkg::HALF_BITS+1:0] s1_mm;

  // Cross term a1*b0 + a0*b1, recovered from the three products.
  logic [2*mult_mod_pkg::HALF_BITS+1:0] mid;

  // Stage two holds the assembled product.
  logic                   s2_val;
  logic [CTL_BITS-1:0]    s2_ctl;
  logic                   s2_err;
  mult_mod_pkg::product_t s2_prod;

  // The pipe moves when the last stage is empty or is being drained.
  assign en    = !s2_val || o_prod.rdy;
  assign o_rdy = en;

  // The half sums need 129 bits, so the middle product is 129 x 129.
  assign sum_a = {1'b0, i_dat_a[mult_mod_pkg::FIELD_BITS-1:mult_mod_pkg::HALF_BITS]} +
                 {1'b0, i_dat_a[mult_mod_pkg::HALF_BITS-1:0]};
  assign sum_b = {1'b0, i_dat_b[mult_mod_pkg::FIELD_BITS-1:mult_mod_pkg::HALF_BITS]} +
                 {1'b0, i_dat_b[mult_mod_pkg::HALF_BITS-1:0]};

  // The middle product minus both outer products is always non-negative.
  assign mid = s1_mm - {2'b00, s1_hh} - {2'b00, s1_ll};

  // Valid bits of both stages.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_val <= 1'b0;
      s2_val <= 1'b0;
    end else if (en) begin
      s1_val <= i_val;
      s2_val <= s1_val;
    end
  end

  // Stage one forms the high, low and middle partial products.
  // The tag and error flag travel alongside.
  always_ff @(posedge i_clk) begin
    if (en) begin
      s1_hh  <= i_dat_a[mult_mod_pkg::FIELD_BITS-1:mult_mod_pkg::HALF_BITS] *
                i_dat_b[mult_mod_pkg::FIELD_BITS-1:mult_mod_pkg::HALF_BITS];
      s1_ll  <= i_dat_a[mult_mod_pkg::HALF_BITS-1:0] * i_dat_b[mult_mod_pkg::HALF_BITS-1:0];
      s1_mm  <= sum_a * sum_b;
      s1_ctl <= i_ctl;
      s1_err <= i_err;
    end
  end

  // Stage two places hh at bit 256, ll at bit 0 and the cross term at bit 128.
  // The outer products do not overlap, so they are simply concatenated.
  always_ff @(posedge i_clk) begin
    if (en) begin
      s2_prod.flat <= {s1_hh, s1_ll} +
                      {{(mult_mod_pkg::PROD_BITS - 3*mult_mod_pkg::HALF_BITS - 2){1'b0}},
                       mid, {mult_mod_pkg::HALF_BITS{1'b0}}};
      s2_ctl       <= s1_ctl;
      s2_err       <= s1_err;
    end
  end

  assign o_prod.dat = s2_prod;
  assign o_prod.ctl = s2_ctl;
  assign o_prod.err = s2_err;
  assign o_prod.val = s2_val;

  // A stalled product must be offered unchanged on the next cycle.
  a_hold_stalled: assert property (@(posedge i_clk) disable iff (i_rst)
    s2_val && !o_prod.rdy |=> s2_val && $stable(s2_prod) && $stable(s2_ctl) && $stable(s2_err))
    else $error("karatsuba_mult: product changed while stalled");

endmodule
`default_nettype wire

/* pipe_fifo.sv */
`default_nettype none
// Two-entry buffer between the multiplier and the reduction.
// It absorbs back-pressure and can accept and deliver in the same cycle.
// A new entry reaches the output one cycle after it is written.
module pipe_fifo #(
  parameter int CTL_BITS = 8
) (
  input  wire      i_clk,
  input  wire      i_rst,
  mult_mod_if.snk  i_in,
  mult_mod_if.src  o_out
);

  // Storage for the two entries.
  mult_mod_pkg::product_t mem_dat [2];
  logic [CTL_BITS-1:0]    mem_ctl [2];
  logic                   mem_err [2];

  // One pointer bit each is enough for two entries.
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;

  // Handshake events on each side.
  logic wr;
  logic rd;

  assign wr = i_in.val && i_in.rdy;
  assign rd = o_out.val && o_out.rdy;

  // Upstream only sees back-pressure when both slots hold data.
  assign i_in.rdy  = (count != 2'd2);
  assign o_out.val = (count != 2'd0);

  // The head entry is always presented, with no bypass from the input.
  assign o_out.dat = mem_dat[rd_ptr];
  assign o_out.ctl = mem_ctl[rd_ptr];
  assign o_out.err = mem_err[rd_ptr];

  always_ff @(posedge i_clk) begin
    if (wr) begin
      mem_dat[wr_ptr] <= i_in.dat;
      mem_ctl[wr_ptr] <= i_in.ctl;
      mem_err[wr_ptr] <= i_in.err;
    end
  end

  // Pointers wrap by toggling.
  // The count moves only when exactly one side transfers.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (wr) begin
        wr_ptr <= ~wr_ptr;
      end
      if (rd) begin
        rd_ptr <= ~rd_ptr;
      end
      case ({wr, rd})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

  // A write while one entry waits must go to the other slot and not over the head.
  a_no_wr_full: assert property (@(posedge i_clk) disable iff (i_rst)
    wr |-> count == 2'd0 || wr_ptr != rd_ptr)
    else $error("pipe_fifo: write into a slot that still holds data");

  // A read with a single entry held must take a slot that was written.
  a_no_rd_empty: assert property (@(posedge i_clk) disable iff (i_rst)
    rd |-> count == 2'd2 || wr_ptr != rd_ptr)
    else $error("pipe_fifo: read from a slot that holds no data");

endmodule
`default_nettype wire

/* secp256k1_mod.sv */
`default_nettype none
// Three-stage reduction of a 512-bit product modulo the secp256k1 prime.
// Two folds with 2^32 + 977 bring the value under 2p, and a final
// conditional subtraction brings it under p.
module secp256k1_mod #(
  parameter int CTL_BITS = 8
) (
  input  wire                                 i_clk,
  input  wire                                 i_rst,
  mult_mod_if.snk                             i_prod,
  output logic [mult_mod_pkg::FIELD_BITS-1:0] o_dat,
  output logic [CTL_BITS-1:0]                 o_ctl,
  output logic                                o_err,
  output logic                                o_val,
  input  wire                                 i_rdy
);

  // Pipe advance enable, shared by all three stages.
  logic en;

  // First fold, lo + hi * FOLD_C, which fits in 290 bits.
  logic [mult_mod_pkg::FIELD_BITS+mult_mod_pkg::FOLD_BITS:0] fold1;
  // Second fold, which stays below 2^256 + 2^67.
  logic [mult_mod_pkg::FIELD_BITS:0] fold2;
  // Candidate result after one subtraction of p.
  logic [mult_mod_pkg::FIELD_BITS:0] diff;

  logic                                                      s1_val;
  logic [CTL_BITS-1:0]                                       s1_ctl;
  logic                                                      s1_err;
  logic [mult_mod_pkg::FIELD_BITS+mult_mod_pkg::FOLD_BITS:0] s1_sum;

  logic                              s2_val;
  logic [CTL_BITS-1:0]               s2_ctl;
  logic                              s2_err;
  logic [mult_mod_pkg::FIELD_BITS:0] s2_sum;

  // Same stall rule as the multiplier.
  assign en         = !o_val || i_rdy;
  assign i_prod.rdy = en;

  // The product is read as two halves here.
  assign fold1 = {{(mult_mod_pkg::FOLD_BITS+1){1'b0}}, i_prod.dat.half.lo} +
                 i_prod.dat.half.hi * mult_mod_pkg::FOLD_C;

  // The 34 bits above 2^256 are folded once more.
  assign fold2 = {1'b0, s1_sum[mult_mod_pkg::FIELD_BITS-1:0]} +
                 s1_sum[mult_mod_pkg::FIELD_BITS+mult_mod_pkg::FOLD_BITS:mult_mod_pkg::FIELD_BITS] *
                 mult_mod_pkg::FOLD_C;

  // fold2 is below 2p, so one subtraction is always enough.
  assign diff = s2_sum - {1'b0, mult_mod_pkg::PRIME_P};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_val <= 1'b0;
      s2_val <= 1'b0;
      o_val  <= 1'b0;
    end else if (en) begin
      s1_val <= i_prod.val;
      s2_val <= s1_val;
      o_val  <= s2_val;
    end
  end

  always_ff @(posedge i_clk) begin
    if (en) begin
      // Stage one.
      s1_sum <= fold1;
      s1_ctl <= i_prod.ctl;
      s1_err <= i_prod.err;
      // Stage two.
      s2_sum <= fold2;
      s2_ctl <= s1_ctl;
      s2_err <= s1_err;
      // Stage three picks the reduced value.
      if (s2_sum >= {1'b0, mult_mod_pkg::PRIME_P}) begin
        o_dat <= diff[mult_mod_pkg::FIELD_BITS-1:0];
      end else begin
        o_dat <= s2_sum[mult_mod_pkg::FIELD_BITS-1:0];
      end
      o_ctl <= s2_ctl;
      o_err <= s2_err;
    end
  end

  // Every result that leaves must be fully reduced.
  a_below_p: assert property (@(posedge i_clk) disable iff (i_rst)
    o_val |-> o_dat < mult_mod_pkg::PRIME_P)
    else $error("secp256k1_mod: result not below p");

endmodule
`default_nettype wire

/* secp256k1_mult_mod.sv */
`default_nettype none
// Top level of the pipelined secp256k1 modular multiplier.
// Multiplier, two-entry buffer and reduction are chained by valid/ready links.
// With i_rdy held high a result leaves 6 cycles after its input is accepted.
module secp256k1_mult_mod #(
  parameter int CTL_BITS = 8
) (
  input  wire                                 i_clk,
  input  wire                                 i_rst,
  // Operand side.
  input  wire [mult_mod_pkg::FIELD_BITS-1:0]  i_dat_a,
  input  wire [mult_mod_pkg::FIELD_BITS-1:0]  i_dat_b,
  input  wire [CTL_BITS-1:0]                  i_ctl,
  input  wire                                 i_val,
  input  wire                                 i_err,
  output logic                                o_rdy,
  // Result side.
  output logic [mult_mod_pkg::FIELD_BITS-1:0] o_dat,
  output logic [CTL_BITS-1:0]                 o_ctl,
  output logic                                o_val,
  output logic                                o_err,
  input  wire                                 i_rdy
);

  // Link from the multiplier into the buffer, and from the buffer to the reduction.
  mult_mod_if #(.CTL_BITS(CTL_BITS)) mult_if (i_clk);
  mult_mod_if #(.CTL_BITS(CTL_BITS)) mod_if (i_clk);

  karatsuba_mult #(.CTL_BITS(CTL_BITS)) u_mult (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_dat_a (i_dat_a),
    .i_dat_b (i_dat_b),
    .i_ctl   (i_ctl),
    .i_err   (i_err),
    .i_val   (i_val),
    .o_rdy   (o_rdy),
    .o_prod  (mult_if)
  );

  pipe_fifo #(.CTL_BITS(CTL_BITS)) u_fifo (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_in  (mult_if),
    .o_out (mod_if)
  );

  secp256k1_mod #(.CTL_BITS(CTL_BITS)) u_mod (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_prod (mod_if),
    .o_dat  (o_dat),
    .o_ctl  (o_ctl),
    .o_err  (o_err),
    .o_val  (o_val),
    .i_rdy  (i_rdy)
  );

endmodule
`default_nettype wire

/* tb_secp256k1_mult_mod.sv */
`default_nettype none
// Testbench for the secp256k1 modular multiplier.
// Runs directed operands, a long random run with the output always ready,
// and a random back-pressure run. Concurrent assertions compare each result
// with a reference queue filled from (a * b) mod p.
module tb_secp256k1_mult_mod;

  localparam int CTL_BITS   = 8;
  localparam int N_DIRECTED = 5;
  localparam int N_RANDOM   = 150;
  localparam int N_BACKPR   = 150;
  localparam int N_TESTS    = N_DIRECTED + N_RANDOM + N_BACKPR;
  // The buffer adds one cycle between the two pipelines.
  localparam int LATENCY    = mult_mod_pkg::MULT_STAGES + 1 + mult_mod_pkg::MOD_STAGES;
  localparam logic [255:0] P = mult_mod_pkg::PRIME_P;

  logic clk;
  logic rst;
  logic [255:0] dat_a;
  logic [255:0] dat_b;
  logic [CTL_BITS-1:0] ctl;
  logic err;
  logic val;
  logic rdy;
  logic dut_rdy;
  logic [255:0] out_dat;
  logic [CTL_BITS-1:0] out_ctl;
  logic out_val;
  logic out_err;

  // Expected results in input order, with the accept cycle of each.
  logic [255:0]        exp_dat_q [$];
  logic [CTL_BITS-1:0] exp_ctl_q [$];
  logic                exp_err_q [$];
  int                  exp_cyc_q [$];
  logic                exp_lat_q [$];

  // Copy of the queue head, read by the assertions.
  logic                have_head;
  logic [255:0]        head_dat;
  logic [CTL_BITS-1:0] head_ctl;
  logic                head_err;
  int                  head_cyc;
  logic                head_lat;

  int   cyc;
  int   seed;
  int   stall_left;
  logic bp_mode;
  logic lat_chk;
  logic saw_rdy_low;
  int   mismatch_cnt;
  int   other_cnt;

  secp256k1_mult_mod #(.CTL_BITS(CTL_BITS)) UUT (
    .i_clk   (clk),
    .i_rst   (rst),
    .i_dat_a (dat_a),
    .i_dat_b (dat_b),
    .i_ctl   (ctl),
    .i_val   (val),
    .i_err   (err),
    .o_rdy   (dut_rdy),
    .o_dat   (out_dat),
    .o_ctl   (out_ctl),
    .o_val   (out_val),
    .o_err   (out_err),
    .i_rdy   (rdy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reference product, reduced with full 512-bit arithmetic.
  function automatic logic [255:0] mod_mul_expected(input logic [255:0] a,
                                                    input logic [255:0] b);
    logic [511:0] rem;
    rem = ({256'b0, a} * {256'b0, b}) % {256'b0, P};
    return rem[255:0];
  endfunction

  // Scoreboard. Pops before it pushes, so the head always belongs to the oldest input.
  always @(posedge clk) begin
    if (!rst && out_val && rdy && exp_dat_q.size() != 0) begin
      void'(exp_dat_q.pop_front());
      void'(exp_ctl_q.pop_front());
      void'(exp_err_q.pop_front());
      void'(exp_cyc_q.pop_front());
      void'(exp_lat_q.pop_front());
    end
    if (!rst && val && dut_rdy) begin
      exp_dat_q.push_back(mod_mul_expected(dat_a, dat_b));
      exp_ctl_q.push_back(ctl);
      exp_err_q.push_back(err);
      exp_cyc_q.push_back(cyc);
      exp_lat_q.push_back(lat_chk);
    end
    if (!rst && !dut_rdy) begin
      saw_rdy_low = 1'b1;
    end
    have_head = (exp_dat_q.size() != 0);
    if (have_head) begin
      head_dat = exp_dat_q[0];
      head_ctl = exp_ctl_q[0];
      head_err = exp_err_q[0];
      head_cyc = exp_cyc_q[0];
      head_lat = exp_lat_q[0];
    end
    cyc = cyc + 1;
  end

  a_dat: assert property (@(posedge clk) disable iff (rst)
    out_val && rdy && have_head |-> out_dat == head_dat)
    else begin
      mismatch_cnt++;
      $display("Mismatch at %0t: o_dat expected %h actual %h",
               $time, $sampled(head_dat), $sampled(out_dat));
    end

  a_ctl: assert property (@(posedge clk) disable iff (rst)
    out_val && rdy && have_head |-> out_ctl == head_ctl && out_err == head_err)
    else begin
      mismatch_cnt++;
      $display("Mismatch at %0t: o_ctl/o_err expected %h/%b actual %h/%b", $time,
               $sampled(head_ctl), $sampled(head_err), $sampled(out_ctl), $sampled(out_err));
    end

  // Only items sent while i_rdy stays high carry the latency flag.
  a_latency: assert property (@(posedge clk) disable iff (rst)
    out_val && rdy && have_head && head_lat |-> cyc == head_cyc + LATENCY)
    else begin
      mismatch_cnt++;
      $display("Mismatch at %0t: latency expected %0d actual %0d",
               $time, LATENCY, $sampled(cyc) - $sampled(head_cyc));
    end

  a_extra: assert property (@(posedge clk) disable iff (rst)
    out_val && rdy |-> have_head)
    else begin
      other_cnt++;
      $display("At %0t a result left with no input waiting for it", $time);
    end

  a_hold: assert property (@(posedge clk) disable iff (rst)
    out_val && !rdy |=> out_val && $stable(out_dat) && $stable(out_ctl) && $stable(out_err))
    else begin
      other_cnt++;
      $display("At %0t the output changed or vanished while i_rdy was low", $time);
    end

  a_reset: assert property (@(posedge clk) $fell(rst) |-> !out_val && dut_rdy)
    else begin
      mismatch_cnt++;
      $display("Mismatch at %0t: o_val/o_rdy after reset expected 0/1 actual %b/%b",
               $time, $sampled(out_val), $sampled(dut_rdy));
    end

  // One clock; in back-pressure mode i_rdy is redrawn, after any forced stall.
  task automatic step_cycle();
    logic [31:0] rnd;
    @(posedge clk);
    if (stall_left > 0) begin
      rdy <= 1'b0;
      stall_left = stall_left - 1;
    end else if (bp_mode) begin
      rnd = $random(seed);
      rdy <= rnd[0];
    end
  endtask

  task automatic rand_field(output logic [255:0] w);
    for (int i = 0; i < 8; i++) begin
      w = {w[223:0], 32'($random(seed))};
    end
  endtask

  // Offers one operand pair and returns on the edge where it is accepted.
  task automatic send_op(input logic [255:0] a, input logic [255:0] b,
                         input logic [CTL_BITS-1:0] c, input logic e);
    dat_a <= a;
    dat_b <= b;
    ctl   <= c;
    err   <= e;
    val   <= 1'b1;
    step_cycle();
    while (!dut_rdy) begin
      step_cycle();
    end
  endtask

  task automatic drain_results();
    val <= 1'b0;
    step_cycle();
    @(negedge clk);
    while (exp_dat_q.size() != 0) begin
      step_cycle();
      @(negedge clk);
    end
    step_cycle();
  endtask

  task automatic send_random(input int count);
    logic [255:0] a;
    logic [255:0] b;
    logic [31:0]  rnd;
    for (int i = 0; i < count; i++) begin
      rand_field(a);
      rand_field(b);
      rnd = $random(seed);
      send_op(a, b, rnd[CTL_BITS-1:0], rnd[CTL_BITS]);
    end
  endtask

  task automatic print_counts();
    $display("Errors: %0d mismatch, %0d other", mismatch_cnt, other_cnt);
  endtask

  initial begin : stimulus
    seed = 32'h9100;
    rst = 1'b1;
    dat_a = '0;
    dat_b = '0;
    ctl = '0;
    err = 1'b0;
    val = 1'b0;
    rdy = 1'b1;
    cyc = 0;
    stall_left = 0;
    bp_mode = 1'b0;
    lat_chk = 1'b1;
    saw_rdy_low = 1'b0;
    have_head = 1'b0;
    mismatch_cnt = 0;
    other_cnt = 0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    // Zero, one, both folds with the final subtraction, and 2^256 itself.
    send_op('0, P - 1, 8'h01, 1'b0);
    send_op(256'd1, P - 1, 8'h02, 1'b1);
    send_op(P - 1, P - 1, 8'h03, 1'b0);
    send_op({1'b1, 255'b0}, 256'd2, 8'h04, 1'b1);
    send_op('1, '1, 8'hA5, 1'b0);
    drain_results();
    send_random(N_RANDOM);
    drain_results();
    // Back-pressure opens with a long stall so the whole pipe fills up.
    lat_chk <= 1'b0;
    bp_mode = 1'b1;
    stall_left = 16;
    send_random(N_BACKPR);
    drain_results();
    bp_mode = 1'b0;
    rdy <= 1'b1;
    repeat (2) step_cycle();
    if (!saw_rdy_low) begin
      other_cnt++;
      $display("o_rdy never dropped while the output was stalled");
    end
    print_counts();
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (N_TESTS * 20 + 200) @(posedge clk);
    $display("Timeout after %0d cycles, results still missing", N_TESTS * 20 + 200);
    print_counts();
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule
`default_nettype wire

/* all.f */
mult_mod_pkg.sv
mult_mod_if.sv
karatsuba_mult.sv
pipe_fifo.sv
secp256k1_mod.sv
secp256k1_mult_mod.sv
tb_secp256k1_mult_mod.sv

/* Bender.yml */
package:
  name: secp256k1_mult_mod

sources:
  - mult_mod_pkg.sv
  - mult_mod_if.sv
  - karatsuba_mult.sv
  - pipe_fifo.sv
  - secp256k1_mod.sv
  - secp256k1_mult_mod.sv
  - target: test
    files:
      - tb_secp256k1_mult_mod.sv
